/* filelist.f */
logic/lsu_pkg.sv
logic/lsu_track_if.sv
logic/lsu_request_gen.sv
logic/lsu_track_fifo.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
testbench/tb_data_mem.sv
testbench/tb_lsu_top.sv

/* run.sh */
#!/bin/sh
# Build the LSU testbench with Verilator and run it
# Exit status follows the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing -Wno-fatal --top-module tb_lsu_top \
            -f filelist.f -o sim_lsu 2>&1 && ./obj_dir/sim_lsu 2>&1) \
  || { echo "$sim_out"; echo "Build or simulation run failed"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* testbench/lsu_cases.txt */
# name we size sign_ext base offset wdata exp_rdata exp_err, all hex after the name
# size 0 byte, 1 halfword, 2 word. Word k of memory starts with every byte at k plus 1
ld_b_o0      0 0 0 00000000 00000000 00000000 00000001 0
ld_b_o1      0 0 1 00000004 00000001 00000000 00000002 0
ld_b_o3      0 0 0 00000000 0000000b 00000000 00000003 0
ld_h_o0      0 1 0 0000000c 00000000 00000000 00000404 0
ld_h_o1      0 1 0 00000010 00000005 00000000 00000606 0
ld_h_o2      0 1 1 00000018 fffffffa 00000000 00000505 0
ld_w_o0      0 2 0 00000018 00000000 00000000 07070707 0
st_b_o2      1 0 0 00000020 00000002 000000a5 00000000 0
st_h_o2      1 1 0 00000024 00000002 00008c3e 00000000 0
st_w_o0      1 2 0 00000028 00000000 deadbeef 00000000 0
ld_w8        0 2 0 00000020 00000000 00000000 09a50909 0
ld_b8_sx     0 0 1 00000020 00000002 00000000 ffffffa5 0
ld_b8_zx     0 0 0 00000022 00000000 00000000 000000a5 0
ld_h9_sx     0 1 1 00000026 00000000 00000000 ffff8c3e 0
ld_w_mis1    0 2 0 00000030 fffffff5 00000000 ef8c3e0a 0
ld_w_mis2    0 2 0 00000020 00000006 00000000 beef8c3e 0
ld_w_mis3    0 2 0 00000027 00000000 00000000 adbeef8c 0
ld_h_mis3    0 1 1 00000024 00000003 00000000 ffffef8c 0
st_w_mis1    1 2 0 0000002c 00000001 11223344 00000000 0
ld_w11       0 2 0 0000002c 00000000 00000000 2233440c 0
ld_w12       0 2 0 00000030 00000000 00000000 0d0d0d11 0
ld_err_hi    0 2 0 00000040 00000000 00000000 00000000 1
ld_err_half2 0 2 0 0000003c 00000002 00000000 00001010 1

/* testbench/tb_lsu_top.sv */
/*
 * Load/store unit testbench
 * Reads instructions with expected results from the case file, issues
 * them back to back against a stalling bus memory, checks bus transfers
 * per instruction and results in issue order
 */

`timescale 1ns/1ns

module tb_lsu_top import lsu_pkg::*; ();

  localparam int          DEPTH       = 2;
  localparam int          MAX_CASES   = 32;
  localparam int          CASE_CYCLES = 40;      // Timeout budget per case
  localparam int unsigned SEED        = 32'h178d_a01f;
  localparam string       CASE_FILE   = "testbench/lsu_cases.txt";

  logic clk;
  logic rst_n;
  // DUT instruction, bus and result signals
  logic              req_valid_i, req_ready_o, req_we_i, req_sign_ext_i;
  lsu_size_e         req_size_i;
  logic [ADDR_W-1:0] req_base_i, req_offset_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic              data_req_o, data_gnt_i, data_we_o;
  logic [ADDR_W-1:0] data_addr_o;
  logic [BE_W-1:0]   data_be_o;
  logic [DATA_W-1:0] data_wdata_o, data_rdata_i;
  logic              data_rvalid_i, data_err_i;
  logic              result_valid_o, result_err_o;
  logic [DATA_W-1:0] result_rdata_o;

  // Case table
  logic [127:0] case_name [MAX_CASES];
  logic         case_we [MAX_CASES];
  logic [1:0]   case_size [MAX_CASES];
  logic         case_sext [MAX_CASES];
  logic [31:0]  case_base [MAX_CASES];
  logic [31:0]  case_offset [MAX_CASES];
  logic [31:0]  case_wdata [MAX_CASES];
  logic [31:0]  case_rdata [MAX_CASES];
  logic         case_exp_err [MAX_CASES];
  int           case_err [MAX_CASES];       // Mismatches per case

  int          n_cases;
  int          errors;
  int          passed;
  int          results_seen;
  int          outstanding;                 // Transfers granted but not answered
  int          cycle_cnt;
  int          timeout_cycles;
  int          pending_q [$];               // Issued cases awaiting a result

  lsu_top #(
    .DEPTH (DEPTH)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_sign_ext_i (req_sign_ext_i),
    .req_base_i     (req_base_i),
    .req_offset_i   (req_offset_i),
    .req_wdata_i    (req_wdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o),
    .result_err_o   (result_err_o)
  );

  tb_data_mem #(
    .WORDS (16)
  ) u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (data_req_o),
    .gnt_o    (data_gnt_i),
    .addr_i   (data_addr_o),
    .we_i     (data_we_o),
    .be_i     (data_be_o),
    .wdata_i  (data_wdata_o),
    .rvalid_o (data_rvalid_i),
    .rdata_o  (data_rdata_i),
    .err_o    (data_err_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                  // 8 ns period
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic compare_value(input int idx, input logic [79:0] field,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
    if (exp_val !== act_val)
    begin
      $display("FAILED %0s %0s expected %h actual %h", case_name[idx], field, exp_val, act_val);
      case_err[idx]++;
      errors++;
    end
  endtask

  // Word at a nonzero offset or halfword at offset 3 crosses a word
  function automatic int transfers_for(input logic [1:0] size, input logic [1:0] off);
    if (size == 2'd2 && off != 2'd0) return 2;
    if (size == 2'd1 && off == 2'd3) return 2;
    return 1;
  endfunction

  // Byte lanes touched in this word and the next, low nibble first
  function automatic logic [7:0] lane_span(input logic [1:0] size, input logic [1:0] off);
    logic [7:0] ones;
    case (size)
      2'd0:    ones = 8'h01;
      2'd1:    ones = 8'h03;
      default: ones = 8'h0f;
    endcase
    return ones << off;
  endfunction

  task automatic load_cases();
    int           fd;
    int           rc;
    logic [127:0] tok;
    logic [959:0] rest;
    logic [31:0]  f_we, f_size, f_sext, f_base, f_off, f_wdata, f_rdata, f_err;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open the case file %0s", CASE_FILE);
      errors++;
    end
    else
    begin
      while ($fscanf(fd, "%s", tok) == 1)
      begin
        if (tok == "#")
        begin
          rc = $fgets(rest, fd);            // Column description line
        end
        else if (n_cases < MAX_CASES)
        begin
          rc = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                       f_we, f_size, f_sext, f_base, f_off, f_wdata, f_rdata, f_err);
          if (rc != 8)
          begin
            $display("Case line %0s is malformed", tok);
            errors++;
          end
          case_name[n_cases]    = tok;
          case_we[n_cases]      = f_we[0];
          case_size[n_cases]    = f_size[1:0];
          case_sext[n_cases]    = f_sext[0];
          case_base[n_cases]    = f_base;
          case_offset[n_cases]  = f_off;
          case_wdata[n_cases]   = f_wdata;
          case_rdata[n_cases]   = f_rdata;
          case_exp_err[n_cases] = f_err[0];
          case_err[n_cases]     = 0;
          n_cases++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Present one instruction until its final grant and check its bus transfers
  task automatic issue_case(input int idx);
    logic [31:0] ea;
    logic [31:0] gaddr [2];
    logic [3:0]  gbe [2];
    logic        gwe [2];
    logic [7:0]  span;
    int          ngrant;
    int          nexp;
    logic        done;
    ea       = case_base[idx] + case_offset[idx];
    nexp     = transfers_for(case_size[idx], ea[1:0]);
    span     = lane_span(case_size[idx], ea[1:0]);
    ngrant   = 0;
    done     = 1'b0;
    gaddr[0] = '0;
    gaddr[1] = '0;
    gbe[0]   = '0;
    gbe[1]   = '0;
    gwe[0]   = 1'b0;
    gwe[1]   = 1'b0;
    @(negedge clk);
    req_valid_i    = 1'b1;
    req_we_i       = case_we[idx];
    req_size_i     = lsu_size_e'(case_size[idx]);
    req_sign_ext_i = case_sext[idx];
    req_base_i     = case_base[idx];
    req_offset_i   = case_offset[idx];
    req_wdata_i    = case_wdata[idx];
    while (!done)
    begin
      @(posedge clk);
      if (data_req_o && data_gnt_i)
      begin
        if (ngrant < 2)
        begin
          gaddr[ngrant] = data_addr_o;
          gbe[ngrant]   = data_be_o;
          gwe[ngrant]   = data_we_o;
        end
        ngrant++;
      end
      if (req_ready_o)
      begin
        pending_q.push_back(idx);           // Result expected later in issue order
        done = 1'b1;
      end
    end
    compare_value(idx, "transfers", 32'(nexp), 32'(ngrant));
    compare_value(idx, "addr0", ea, gaddr[0]);
    compare_value(idx, "be0", 32'(span[3:0]), 32'(gbe[0]));
    compare_value(idx, "we0", 32'(case_we[idx]), 32'(gwe[0]));
    if (nexp == 2)
    begin
      compare_value(idx, "addr1", {ea[31:2], 2'b00} + 32'd4, gaddr[1]);
      compare_value(idx, "be1", 32'(span[7:4]), 32'(gbe[1]));
      compare_value(idx, "we1", 32'(case_we[idx]), 32'(gwe[1]));
    end
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n && result_valid_o)
    begin
      if (pending_q.size() == 0)
      begin
        $display("Result strobe seen with no instruction outstanding");
        errors++;
      end
      else
      begin
        automatic int idx = pending_q.pop_front();
        compare_value(idx, "rdata", case_rdata[idx], result_rdata_o);
        compare_value(idx, "err", 32'(case_exp_err[idx]), 32'(result_err_o));
        if (case_err[idx] == 0)
        begin
          passed++;
          $display("case %0s done, ok", case_name[idx]);
        end
        else
          $display("case %0s done, %0d mismatches", case_name[idx], case_err[idx]);
        results_seen++;
      end
    end
  end

  always @(posedge clk)
  begin
    if (!rst_n)
      outstanding = 0;
    else
    begin
      if (data_req_o && data_gnt_i) outstanding++;
      if (data_rvalid_i) outstanding--;
      if (outstanding > DEPTH)
      begin
        $display("Outstanding transfers reached %0d, above the limit of %0d",
                 outstanding, DEPTH);
        errors++;
      end
    end
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles)
    begin
      $display("Timed out after %0d cycles with %0d of %0d results seen",
               cycle_cnt, results_seen, n_cases);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    rst_n          = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_size_i     = SIZE_BYTE;
    req_sign_ext_i = 1'b0;
    req_base_i     = '0;
    req_offset_i   = '0;
    req_wdata_i    = '0;
    n_cases        = 0;
    errors         = 0;
    passed         = 0;
    results_seen   = 0;
    cycle_cnt      = 0;
    load_cases();
    timeout_cycles = n_cases * CASE_CYCLES;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_cases; i++)
      issue_case(i);
    @(negedge clk);
    req_valid_i = 1'b0;
    wait (results_seen == n_cases);
    repeat (4) @(posedge clk);              // Catch any stray result strobe
    $display("Cases %0d, passed %0d, failed %0d, errors %0d",
             n_cases, passed, n_cases - passed, errors);
    if (errors == 0 && n_cases > 0 && passed == n_cases)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* testbench/tb_data_mem.sv */
/*
 * Data bus memory model
 * 16 words with random grant stalls, byte enable writes and in order
 * responses 1 to 3 cycles after each accepted transfer.
 * Addresses past the end answer with an error and zero data
 */

`timescale 1ns/1ns

module tb_data_mem #(
  parameter int WORDS = 16
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  output logic        gnt_o,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  localparam int AW = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  int          stall_cnt;                   // Idle cycles left before the next grant
  int          cyc;                         // Edge count, due times refer to it
  int          last_due;                    // Keeps responses in bus order
  int          due;
  logic [31:0] rd_word;
  logic        rd_err;
  int          due_q [$];                   // Pending responses, oldest first
  logic [31:0] rdata_q [$];
  logic        err_q [$];

  ////////////////////////////////////////
  // Sampling on the rising edge
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < WORDS; i++)
        mem[i] = 32'h0101_0101 * (i + 1);   // Each byte holds the word number plus one
      due_q.delete();
      rdata_q.delete();
      err_q.delete();
      stall_cnt = 0;
      cyc       = 0;
      last_due  = 0;
    end
    else
    begin
      if (rvalid_o)
      begin
        due_q.pop_front();                  // Response taken at this edge
        rdata_q.pop_front();
        err_q.pop_front();
      end
      if (req_i && gnt_o)
      begin
        rd_err  = (addr_i >= 32'(WORDS * 4));
        rd_word = '0;
        if (!rd_err)
        begin
          if (we_i)
            for (int b = 0; b < 4; b++)
              if (be_i[b]) mem[addr_i[AW+1:2]][8*b +: 8] = wdata_i[8*b +: 8];
          rd_word = mem[addr_i[AW+1:2]];
        end
        due = cyc + int'($urandom_range(3, 1));
        if (due <= last_due) due = last_due + 1;   // No overtaking
        last_due = due;
        due_q.push_back(due);
        rdata_q.push_back(rd_word);
        err_q.push_back(rd_err);
        stall_cnt = int'($urandom_range(2, 0));
      end
      else if (req_i && stall_cnt > 0)
      begin
        stall_cnt--;                        // Request waits out the stall
      end
      cyc++;
    end
  end

  ////////////////////////////////////////
  // Driving on the falling edge
  ////////////////////////////////////////

  initial
  begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    forever
    begin
      @(negedge clk);
      gnt_o    = rst_n && (stall_cnt == 0);
      rvalid_o = 1'b0;
      rdata_o  = '0;
      err_o    = 1'b0;
      if (rst_n && due_q.size() > 0)
      begin
        if (due_q[0] <= cyc)                // Oldest response is due
        begin
          rvalid_o = 1'b1;
          rdata_o  = rdata_q[0];
          err_o    = err_q[0];
        end
      end
    end
  end

endmodule

/* logic/lsu_top.sv */
/*
 * Load/store unit top level
 * Request generator, outstanding transfer FIFO and read data aligner
 * joined by the tracking channel, with plain instruction, bus and
 * result ports
 */

`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; #(
  parameter int DEPTH = 2                   // Max outstanding bus transfers
) (
  input  logic              clk,
  input  logic              rst_n,
  // Instruction side
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_we_i,
  input  lsu_size_e         req_size_i,
  input  logic              req_sign_ext_i,
  input  logic [ADDR_W-1:0] req_base_i,
  input  logic [ADDR_W-1:0] req_offset_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  // Data bus
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output logic [ADDR_W-1:0] data_addr_o,
  output logic              data_we_o,
  output logic [BE_W-1:0]   data_be_o,
  output logic [DATA_W-1:0] data_wdata_o,
  input  logic              data_rvalid_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  input  logic              data_err_i,
  // Result side
  output logic              result_valid_o,
  output logic [DATA_W-1:0] result_rdata_o,
  output logic              result_err_o
);

  lsu_track_if trk_if ();                   // Producer to buffer to consumer

  // Producer
  lsu_request_gen u_request_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_we_i       (req_we_i),
    .req_size_i     (req_size_i),
    .req_sign_ext_i (req_sign_ext_i),
    .req_base_i     (req_base_i),
    .req_offset_i   (req_offset_i),
    .req_wdata_i    (req_wdata_i),
    .req_ready_o    (req_ready_o),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .trk            (trk_if.producer)
  );

  // Buffer
  lsu_track_fifo #(
    .DEPTH (DEPTH)
  ) u_track_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .trk   (trk_if.buffer)
  );

  // Consumer
  lsu_rdata_align u_rdata_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i),
    .trk            (trk_if.consumer),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o),
    .result_err_o   (result_err_o)
  );

endmodule

/* logic/lsu_rdata_align.sv */
/*
 * Read data aligner
 * Pops one tracking entry per bus response, keeps the first half of
 * a split load, then aligns, assembles and extends the load result.
 * Strobes one result per instruction with the merged bus error
 */

`timescale 1ns/1ns

module lsu_rdata_align import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Data bus response channel
  input  logic              data_rvalid_i,
  input  logic [DATA_W-1:0] data_rdata_i,
  input  logic              data_err_i,
  // Tracking FIFO
  lsu_track_if.consumer     trk,
  // Result side
  output logic              result_valid_o,
  output logic [DATA_W-1:0] result_rdata_o,
  output logic              result_err_o
);

  lsu_track_t        head;                  // Entry for the response in flight
  logic              straddle;              // Head is the second half of a split access
  logic [DATA_W-1:0] rdata_q;               // First half read data
  logic              err_q;                 // First half bus error
  logic [DATA_W-1:0] word_asm;
  logic [15:0]       half_raw;
  logic [7:0]        byte_raw;
  logic [DATA_W-1:0] rdata_ext;

  assign head    = trk.head_entry;
  assign trk.pop = data_rvalid_i;           // Every response retires one entry

  always_comb
  begin
    case (head.size)
      SIZE_BYTE: straddle = 1'b0;
      SIZE_HALF: straddle = (head.offset == 2'b11);
      default:   straddle = (head.offset != 2'b00);
    endcase
  end

  ////////////////////////////////////////
  // First half capture
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !head.last)
    begin
      rdata_q <= data_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      err_q <= 1'b0;
    end
    else if (data_rvalid_i && !head.last)
    begin
      err_q <= data_err_i;
    end
  end

  ////////////////////////////////////////
  // Alignment and extension
  ////////////////////////////////////////

  always_comb
  begin
    // Upper bytes come from the new word, lower ones from the saved half
    case (head.offset)
      2'b00:   word_asm = data_rdata_i;
      2'b01:   word_asm = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   word_asm = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_asm = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
    case (head.offset)
      2'b00:   half_raw = data_rdata_i[15:0];
      2'b01:   half_raw = data_rdata_i[23:8];
      2'b10:   half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], rdata_q[31:24]};  // Split halfword
    endcase
    byte_raw = data_rdata_i[8*head.offset +: 8];
    case (head.size)
      SIZE_BYTE: rdata_ext = {{24{head.sign_ext && byte_raw[7]}}, byte_raw};
      SIZE_HALF: rdata_ext = {{16{head.sign_ext && half_raw[15]}}, half_raw};
      default:   rdata_ext = word_asm;
    endcase
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  assign result_valid_o = data_rvalid_i && !trk.empty && head.last;
  assign result_rdata_o = head.we ? '0 : rdata_ext;        // Stores return zero
  assign result_err_o   = result_valid_o && (data_err_i || (straddle && err_q));

endmodule

/* logic/lsu_track_fifo.sv */
/*
 * Outstanding transfer FIFO
 * Circular buffer of tracking entries, one per granted transfer,
 * read in order as responses return. Holds up to DEPTH entries
 */

`timescale 1ns/1ns

module lsu_track_fifo import lsu_pkg::*; #(
  parameter int DEPTH = 2                   // Max outstanding transfers (2 or more)
) (
  input  logic          clk,
  input  logic          rst_n,
  lsu_track_if.buffer   trk
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_track_t       mem [DEPTH];            // Entry storage
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;                // Occupancy
  logic             do_push;
  logic             do_pop;

  // Pointer advance with wrap for any DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign do_push = trk.push && !trk.full;
  assign do_pop  = trk.pop && !trk.empty;

  assign trk.full       = (count_q == CNT_W'(DEPTH));
  assign trk.empty      = (count_q == '0);
  assign trk.head_entry = mem[rd_ptr_q];    // Oldest entry when not empty

  ////////////////////////////////////////
  // Storage write
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr_q] <= trk.push_entry;
    end
  end

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;        // Push with pop keeps the count
      endcase
    end
  end

endmodule

/* logic/lsu_request_gen.sv */
/*
 * Load/store request generator
 * Forms base plus offset, byte enables and rotated store data, and
 * splits accesses that cross a word boundary into two bus transfers.
 * Pushes one tracking entry for every granted transfer
 */

`timescale 1ns/1ns

module lsu_request_gen import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Instruction side
  input  logic              req_valid_i,
  input  logic              req_we_i,
  input  lsu_size_e         req_size_i,
  input  logic              req_sign_ext_i,
  input  logic [ADDR_W-1:0] req_base_i,
  input  logic [ADDR_W-1:0] req_offset_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  output logic              req_ready_o,
  // Data bus request channel
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output logic [ADDR_W-1:0] data_addr_o,
  output logic              data_we_o,
  output logic [BE_W-1:0]   data_be_o,
  output logic [DATA_W-1:0] data_wdata_o,
  // Tracking FIFO
  lsu_track_if.producer     trk
);

  logic              phase_q;               // First half of a split access granted
  logic [ADDR_W-1:0] addr_sum;              // Effective address of the current phase
  logic [1:0]        byte_off;              // Same in both phases, +4 keeps bits 1:0
  logic              misaligned;            // Access crosses a word boundary
  logic              grant;                 // Transfer accepted this cycle
  logic [BE_W-1:0]   be;

  ////////////////////////////////////////
  // Address
  ////////////////////////////////////////

  assign addr_sum = req_base_i + req_offset_i + (phase_q ? ADDR_W'(4) : ADDR_W'(0));
  assign byte_off = addr_sum[1:0];

  // Words at any nonzero offset, halfwords only at offset 3
  always_comb
  begin
    case (req_size_i)
      SIZE_BYTE: misaligned = 1'b0;
      SIZE_HALF: misaligned = (byte_off == 2'b11);
      default:   misaligned = (byte_off != 2'b00);
    endcase
  end

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  always_comb
  begin
    case (req_size_i)
      SIZE_BYTE:
      begin
        be = 4'b0001 << byte_off;           // Single lane at the offset
      end
      SIZE_HALF:
      begin
        if (!phase_q)
        begin
          case (byte_off)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;          // Low byte only, rest goes next word
          endcase
        end
        else
        begin
          be = 4'b0001;                     // Upper byte of a split halfword
        end
      end
      default:
      begin
        if (!phase_q)
        begin
          case (byte_off)
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end
        else
        begin
          case (byte_off)
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            2'b11:   be = 4'b0111;
            default: be = 4'b0000;          // Aligned words never get here
          endcase
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////

  assign data_req_o   = req_valid_i && !trk.full;            // No request past DEPTH
  assign grant        = data_req_o && data_gnt_i;
  assign data_addr_o  = phase_q ? {addr_sum[ADDR_W-1:2], 2'b00} : addr_sum;
  assign data_we_o    = req_we_i;
  assign data_be_o    = be;
  // Rotate left by the byte offset, spilled bytes land in lane 0 of the next word
  assign data_wdata_o = (req_wdata_i << (8 * byte_off)) | (req_wdata_i >> (8 * (4 - byte_off)));

  // Instruction done with its final grant
  assign req_ready_o  = grant && (phase_q || !misaligned);

  // Split state, set on first half grant, cleared on second
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase_q <= 1'b0;
    end
    else if (grant)
    begin
      phase_q <= !phase_q && misaligned;
    end
  end

  ////////////////////////////////////////
  // Tracking entry
  ////////////////////////////////////////

  assign trk.push                = grant;
  assign trk.push_entry.we       = req_we_i;
  assign trk.push_entry.size     = req_size_i;
  assign trk.push_entry.sign_ext = req_sign_ext_i;
  assign trk.push_entry.offset   = byte_off;
  assign trk.push_entry.last     = phase_q || !misaligned;  // Cleared for a first half

endmodule

/* logic/lsu_track_if.sv */
/*
 * Outstanding transfer tracking channel
 * Carries push and pop of control entries between the request
 * generator, the tracking FIFO and the read data aligner
 */

`timescale 1ns/1ns

interface lsu_track_if import lsu_pkg::*; ();

  logic       push;                         // Transfer accepted on the bus
  lsu_track_t push_entry;                   // Control info of that transfer
  logic       full;                         // DEPTH transfers outstanding
  logic       pop;                          // Response seen on the bus
  lsu_track_t head_entry;                   // Oldest outstanding transfer
  logic       empty;                        // Nothing outstanding

  // Request side
  modport producer (output push, output push_entry, input full);

  // FIFO storage
  modport buffer (input push, input push_entry, input pop,
                  output full, output head_entry, output empty);

  // Response side
  modport consumer (output pop, input head_entry, input empty);

endinterface

/* logic/lsu_pkg.sv */
/*
 * Load/store unit shared definitions
 * Bus widths, the access size encoding and the control entry that
 * follows each outstanding bus transfer from request to response
 */

package lsu_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int ADDR_W = 32;               // Byte address width
  localparam int DATA_W = 32;               // Data bus width
  localparam int BE_W   = DATA_W / 8;       // One enable per byte lane, 4

  ////////////////////////////////////////
  // Access size
  ////////////////////////////////////////

  // Same encoding as the funct3 low bits of RISC-V loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  ////////////////////////////////////////
  // Tracking entry
  ////////////////////////////////////////

  // One entry per accepted bus transfer, consumed by the response side
  typedef struct packed {
    logic      we;                          // Transfer is a store
    lsu_size_e size;                        // Size of the whole instruction
    logic      sign_ext;                    // Sign extend the load result
    logic [1:0] offset;                     // Byte offset of the instruction address
    logic      last;                        // Final transfer of its instruction
  } lsu_track_t;

endpackage
